//--- logic/rv_defs.svh
/* rv64i decode widths */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data path width
`define XLEN 64

// instruction word width
`define ILEN 32

// register file index
`define RIDX_W 5

// micro-operation code width
`define UOP_W 8

// return address step after jal and jalr
`define LINK_OFS 4

`endif

//--- logic/isa_pkg.sv
/* rv64i instruction formats */
`include "rv_defs.svh"

package isa_pkg;

  // major opcodes of the kept instruction set
  typedef enum logic [6:0] {
    opc_load      = 7'b0000011,
    opc_op_imm    = 7'b0010011,
    opc_auipc     = 7'b0010111,
    opc_op_imm_32 = 7'b0011011,
    opc_store     = 7'b0100011,
    opc_op        = 7'b0110011,
    opc_lui       = 7'b0110111,
    opc_op_32     = 7'b0111011,
    opc_branch    = 7'b1100011,
    opc_jalr      = 7'b1100111,
    opc_jal       = 7'b1101111
  } opcode_e;

  typedef struct packed {
    logic [6:0]         funct7;
    logic [`RIDX_W-1:0] rs2;
    logic [`RIDX_W-1:0] rs1;
    logic [2:0]         funct3;
    logic [`RIDX_W-1:0] rd;
    opcode_e            opcode;
  } r_fmt_t;

  // shift-immediates keep funct6 and shamt inside imm
  typedef struct packed {
    logic [11:0]        imm;
    logic [`RIDX_W-1:0] rs1;
    logic [2:0]         funct3;
    logic [`RIDX_W-1:0] rd;
    opcode_e            opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]         imm_hi;
    logic [`RIDX_W-1:0] rs2;
    logic [`RIDX_W-1:0] rs1;
    logic [2:0]         funct3;
    logic [4:0]         imm_lo;
    opcode_e            opcode;
  } s_fmt_t;

  typedef struct packed {
    logic               imm12;
    logic [5:0]         imm10_5;
    logic [`RIDX_W-1:0] rs2;
    logic [`RIDX_W-1:0] rs1;
    logic [2:0]         funct3;
    logic [3:0]         imm4_1;
    logic               imm11;
    opcode_e            opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]        imm;
    logic [`RIDX_W-1:0] rd;
    opcode_e            opcode;
  } u_fmt_t;

  typedef struct packed {
    logic               imm20;
    logic [9:0]         imm10_1;
    logic               imm11;
    logic [7:0]         imm19_12;
    logic [`RIDX_W-1:0] rd;
    opcode_e            opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

endpackage

//--- logic/decode_pkg.sv
/* decode results */
`include "rv_defs.svh"

package decode_pkg;

  // numbered in order from zero
  typedef enum logic [`UOP_W-1:0] {
    uop_none,
    uop_lui,
    uop_auipc,
    uop_jal,
    uop_jalr,
    uop_beq,
    uop_bne,
    uop_blt,
    uop_bge,
    uop_bltu,
    uop_bgeu,
    uop_lb,
    uop_lh,
    uop_lw,
    uop_ld,
    uop_lbu,
    uop_lhu,
    uop_lwu,
    uop_sb,
    uop_sh,
    uop_sw,
    uop_sd,
    uop_addi, uop_slti, uop_sltiu, uop_xori, uop_ori, uop_andi,
    uop_slli, uop_srli, uop_srai,
    uop_add, uop_sub, uop_sll, uop_slt, uop_sltu,
    uop_xor, uop_srl, uop_sra, uop_or, uop_and,
    uop_addiw, uop_slliw, uop_srliw, uop_sraiw,
    uop_addw, uop_subw, uop_sllw, uop_srlw, uop_sraw
  } uop_e;

  typedef enum logic [2:0] {
    fmt_none,
    fmt_r,
    fmt_i,
    fmt_s,
    fmt_b,
    fmt_u,
    fmt_j
  } fmt_e;

  // one instruction handed to execute
  typedef struct packed {
    logic               valid;
    uop_e               uop;
    logic               rs1_ren;
    logic [`RIDX_W-1:0] rs1;
    logic               rs2_ren;
    logic [`RIDX_W-1:0] rs2;
    logic               rd_wen;
    logic [`RIDX_W-1:0] rd;
    logic [`XLEN-1:0]   op1;
    logic [`XLEN-1:0]   op2;
    logic [`XLEN-1:0]   op3;
  } id_out_t;

endpackage

//--- logic/decode_if.sv
/* classifier decisions */
interface decode_if;

  decode_pkg::fmt_e fmt;
  decode_pkg::uop_e uop;
  logic             is_shamt;
  logic             is_word;
  logic             rs1_ren;
  logic             rs2_ren;
  logic             rd_wen;

  modport cls (
    output fmt,
    output uop,
    output is_shamt,
    output is_word,
    output rs1_ren,
    output rs2_ren,
    output rd_wen
  );

  modport dp (
    input fmt,
    input uop,
    input is_shamt,
    input is_word,
    input rs1_ren,
    input rs2_ren,
    input rd_wen
  );

endinterface

//--- logic/inst_classifier.sv
/* instruction classifier */
module inst_classifier (
  input  isa_pkg::inst_u i_inst,
  decode_if.cls          dec
);

  decode_pkg::uop_e uop;
  decode_pkg::fmt_e fmt_sel;
  logic             shamt_sel;
  logic             word_sel;
  logic             known;
  logic [2:0]       funct3;
  logic             alt;

  assign funct3 = i_inst.r.funct3;
  // instruction bit 30 picks sub and the arithmetic shifts
  assign alt    = i_inst.r.funct7[5];

  always_comb begin
    uop       = decode_pkg::uop_none;
    fmt_sel   = decode_pkg::fmt_none;
    shamt_sel = 1'b0;
    word_sel  = 1'b0;
    case (i_inst.r.opcode)
      isa_pkg::opc_lui: begin
        uop     = decode_pkg::uop_lui;
        fmt_sel = decode_pkg::fmt_u;
      end
      isa_pkg::opc_auipc: begin
        uop     = decode_pkg::uop_auipc;
        fmt_sel = decode_pkg::fmt_u;
      end
      isa_pkg::opc_jal: begin
        uop     = decode_pkg::uop_jal;
        fmt_sel = decode_pkg::fmt_j;
      end
      isa_pkg::opc_jalr: begin
        fmt_sel = decode_pkg::fmt_i;
        if (funct3 == 3'd0) begin
          uop = decode_pkg::uop_jalr;
        end
      end
      isa_pkg::opc_branch: begin
        fmt_sel = decode_pkg::fmt_b;
        case (funct3)
          3'd0:    uop = decode_pkg::uop_beq;
          3'd1:    uop = decode_pkg::uop_bne;
          3'd4:    uop = decode_pkg::uop_blt;
          3'd5:    uop = decode_pkg::uop_bge;
          3'd6:    uop = decode_pkg::uop_bltu;
          3'd7:    uop = decode_pkg::uop_bgeu;
          default: uop = decode_pkg::uop_none;
        endcase
      end
      isa_pkg::opc_load: begin
        fmt_sel = decode_pkg::fmt_i;
        case (funct3)
          3'd0:    uop = decode_pkg::uop_lb;
          3'd1:    uop = decode_pkg::uop_lh;
          3'd2:    uop = decode_pkg::uop_lw;
          3'd3:    uop = decode_pkg::uop_ld;
          3'd4:    uop = decode_pkg::uop_lbu;
          3'd5:    uop = decode_pkg::uop_lhu;
          3'd6:    uop = decode_pkg::uop_lwu;
          default: uop = decode_pkg::uop_none;
        endcase
      end
      isa_pkg::opc_store: begin
        fmt_sel = decode_pkg::fmt_s;
        case (funct3)
          3'd0:    uop = decode_pkg::uop_sb;
          3'd1:    uop = decode_pkg::uop_sh;
          3'd2:    uop = decode_pkg::uop_sw;
          3'd3:    uop = decode_pkg::uop_sd;
          default: uop = decode_pkg::uop_none;
        endcase
      end
      isa_pkg::opc_op_imm: begin
        fmt_sel   = decode_pkg::fmt_i;
        shamt_sel = (funct3 == 3'd1) || (funct3 == 3'd5);
        case (funct3)
          3'd0: uop = decode_pkg::uop_addi;
          3'd1: uop = decode_pkg::uop_slli;
          3'd2: uop = decode_pkg::uop_slti;
          3'd3: uop = decode_pkg::uop_sltiu;
          3'd4: uop = decode_pkg::uop_xori;
          3'd5: begin
            if (alt) uop = decode_pkg::uop_srai;
            else     uop = decode_pkg::uop_srli;
          end
          3'd6: uop = decode_pkg::uop_ori;
          default: uop = decode_pkg::uop_andi;
        endcase
      end
      isa_pkg::opc_op_imm_32: begin
        fmt_sel   = decode_pkg::fmt_i;
        word_sel  = 1'b1;
        shamt_sel = (funct3 == 3'd1) || (funct3 == 3'd5);
        case (funct3)
          3'd0: uop = decode_pkg::uop_addiw;
          3'd1: uop = decode_pkg::uop_slliw;
          3'd5: begin
            if (alt) uop = decode_pkg::uop_sraiw;
            else     uop = decode_pkg::uop_srliw;
          end
          default: uop = decode_pkg::uop_none;
        endcase
      end
      isa_pkg::opc_op: begin
        fmt_sel = decode_pkg::fmt_r;
        case (funct3)
          3'd0: begin
            if (alt) uop = decode_pkg::uop_sub;
            else     uop = decode_pkg::uop_add;
          end
          3'd1: uop = decode_pkg::uop_sll;
          3'd2: uop = decode_pkg::uop_slt;
          3'd3: uop = decode_pkg::uop_sltu;
          3'd4: uop = decode_pkg::uop_xor;
          3'd5: begin
            if (alt) uop = decode_pkg::uop_sra;
            else     uop = decode_pkg::uop_srl;
          end
          3'd6: uop = decode_pkg::uop_or;
          default: uop = decode_pkg::uop_and;
        endcase
      end
      isa_pkg::opc_op_32: begin
        fmt_sel  = decode_pkg::fmt_r;
        word_sel = 1'b1;
        case (funct3)
          3'd0: begin
            if (alt) uop = decode_pkg::uop_subw;
            else     uop = decode_pkg::uop_addw;
          end
          3'd1: uop = decode_pkg::uop_sllw;
          3'd5: begin
            if (alt) uop = decode_pkg::uop_sraw;
            else     uop = decode_pkg::uop_srlw;
          end
          default: uop = decode_pkg::uop_none;
        endcase
      end
      default: ;
    endcase
  end

  // unsupported words carry no class and no flags
  assign known = (uop != decode_pkg::uop_none);

  always_comb begin
    dec.uop      = uop;
    dec.fmt      = decode_pkg::fmt_none;
    dec.is_shamt = 1'b0;
    dec.is_word  = 1'b0;
    if (known) begin
      dec.fmt      = fmt_sel;
      dec.is_shamt = shamt_sel;
      dec.is_word  = word_sel;
    end
  end

  assign dec.rs1_ren = known && (fmt_sel inside {decode_pkg::fmt_r, decode_pkg::fmt_i,
                                                 decode_pkg::fmt_s, decode_pkg::fmt_b});
  assign dec.rs2_ren = known && (fmt_sel inside {decode_pkg::fmt_r, decode_pkg::fmt_s,
                                                 decode_pkg::fmt_b});
  assign dec.rd_wen  = known && (fmt_sel inside {decode_pkg::fmt_r, decode_pkg::fmt_i,
                                                 decode_pkg::fmt_u, decode_pkg::fmt_j});

endmodule

//--- logic/imm_gen.sv
/* immediate generator */
`include "rv_defs.svh"

module imm_gen (
  input  isa_pkg::inst_u   i_inst,
  decode_if.dp             dec,
  output logic [`XLEN-1:0] o_imm
);

  always_comb begin
    o_imm = '0;
    case (dec.fmt)
      decode_pkg::fmt_i: begin
        if (dec.is_shamt && dec.is_word) begin
          o_imm = {{(`XLEN-5){1'b0}}, i_inst.i.imm[4:0]};
        end else if (dec.is_shamt) begin
          o_imm = {{(`XLEN-6){1'b0}}, i_inst.i.imm[5:0]};
        end else begin
          o_imm = {{(`XLEN-12){i_inst.i.imm[11]}}, i_inst.i.imm};
        end
      end
      decode_pkg::fmt_s: begin
        o_imm = {{(`XLEN-12){i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
      end
      decode_pkg::fmt_b: begin
        o_imm = {{(`XLEN-12){i_inst.b.imm12}}, i_inst.b.imm11, i_inst.b.imm10_5,
                 i_inst.b.imm4_1, 1'b0};
      end
      decode_pkg::fmt_u: begin
        o_imm = {{(`XLEN-32){i_inst.u.imm[19]}}, i_inst.u.imm, 12'b0};
      end
      decode_pkg::fmt_j: begin
        o_imm = {{(`XLEN-20){i_inst.j.imm20}}, i_inst.j.imm19_12, i_inst.j.imm11,
                 i_inst.j.imm10_1, 1'b0};
      end
      // r format has no immediate
      default: o_imm = '0;
    endcase
  end

endmodule

//--- logic/operand_mux.sv
/* operand select */
`include "rv_defs.svh"

module operand_mux (
  input  isa_pkg::inst_u      i_inst,
  input  logic                i_valid,
  input  logic [`XLEN-1:0]    i_pc,
  input  logic [`XLEN-1:0]    i_rs1_data,
  input  logic [`XLEN-1:0]    i_rs2_data,
  input  logic [`XLEN-1:0]    i_imm,
  decode_if.dp                dec,
  output decode_pkg::id_out_t o_bundle
);

  logic [`XLEN-1:0] target;
  logic [`XLEN-1:0] link;
  logic             is_load;

  // one adder serves branch and jal targets
  assign target  = i_pc + i_imm;
  assign link    = i_pc + `XLEN'(`LINK_OFS);
  assign is_load = (i_inst.i.opcode == isa_pkg::opc_load);

  always_comb begin
    o_bundle = '0;
    if (i_valid) begin
      o_bundle.valid   = 1'b1;
      o_bundle.uop     = dec.uop;
      o_bundle.rs1_ren = dec.rs1_ren;
      o_bundle.rs2_ren = dec.rs2_ren;
      o_bundle.rd_wen  = dec.rd_wen;
      o_bundle.rs1     = dec.rs1_ren ? i_inst.r.rs1 : '0;
      o_bundle.rs2     = dec.rs2_ren ? i_inst.r.rs2 : '0;
      o_bundle.rd      = dec.rd_wen ? i_inst.r.rd : '0;
      case (dec.fmt)
        decode_pkg::fmt_r: begin
          o_bundle.op1 = i_rs1_data;
          o_bundle.op2 = i_rs2_data;
        end
        decode_pkg::fmt_i: begin
          o_bundle.op1 = i_rs1_data;
          o_bundle.op2 = i_imm;
          if (is_load) begin
            o_bundle.op3 = i_imm;
          end else if (dec.uop == decode_pkg::uop_jalr) begin
            o_bundle.op3 = link;
          end
        end
        decode_pkg::fmt_s: begin
          o_bundle.op1 = i_rs1_data;
          o_bundle.op2 = i_rs2_data;
          o_bundle.op3 = i_imm;
        end
        decode_pkg::fmt_b: begin
          o_bundle.op1 = i_rs1_data;
          o_bundle.op2 = i_rs2_data;
          o_bundle.op3 = target;
        end
        decode_pkg::fmt_u: begin
          o_bundle.op1 = i_imm;
          o_bundle.op2 = i_pc;
        end
        decode_pkg::fmt_j: begin
          o_bundle.op1 = i_pc;
          o_bundle.op2 = `XLEN'(`LINK_OFS);
          o_bundle.op3 = target;
        end
        default: ;
      endcase
    end
  end

endmodule

//--- logic/id_ex_reg.sv
/* id to ex register */
module id_ex_reg (
  input  logic                clock,
  input  logic                rst,
  input  decode_pkg::id_out_t i_bundle,
  output decode_pkg::id_out_t o_bundle
);

  decode_pkg::id_out_t stage_q;

  // bubbles arrive already zeroed, so the stage just samples
  always_ff @(posedge clock) begin
    if (rst) begin
      stage_q <= '0;
    end else begin
      stage_q <= i_bundle;
    end
  end

  assign o_bundle = stage_q;

endmodule

//--- logic/id_stage_top.sv
/* rv64i decode stage */
`include "rv_defs.svh"

module id_stage_top (
  input  logic                clock,
  input  logic                rst,
  input  logic                i_valid,
  input  logic [`ILEN-1:0]    i_inst,
  input  logic [`XLEN-1:0]    i_pc,
  input  logic [`XLEN-1:0]    i_rs1_data,
  input  logic [`XLEN-1:0]    i_rs2_data,
  output logic                o_valid,
  output logic [`UOP_W-1:0]   o_uop,
  output logic                o_rs1_ren,
  output logic [`RIDX_W-1:0]  o_rs1,
  output logic                o_rs2_ren,
  output logic [`RIDX_W-1:0]  o_rs2,
  output logic                o_rd_wen,
  output logic [`RIDX_W-1:0]  o_rd,
  output logic [`XLEN-1:0]    o_op1,
  output logic [`XLEN-1:0]    o_op2,
  output logic [`XLEN-1:0]    o_op3
);

  isa_pkg::inst_u      inst;
  logic [`XLEN-1:0]    imm;
  decode_pkg::id_out_t id_bundle;
  decode_pkg::id_out_t ex_bundle;

  decode_if dec_if ();

  assign inst = i_inst;

  inst_classifier u_classifier (
    .i_inst (inst),
    .dec    (dec_if.cls)
  );

  imm_gen u_imm_gen (
    .i_inst (inst),
    .dec    (dec_if.dp),
    .o_imm  (imm)
  );

  operand_mux u_operand_mux (
    .i_inst     (inst),
    .i_valid    (i_valid),
    .i_pc       (i_pc),
    .i_rs1_data (i_rs1_data),
    .i_rs2_data (i_rs2_data),
    .i_imm      (imm),
    .dec        (dec_if.dp),
    .o_bundle   (id_bundle)
  );

  id_ex_reg u_id_ex_reg (
    .clock    (clock),
    .rst      (rst),
    .i_bundle (id_bundle),
    .o_bundle (ex_bundle)
  );

  assign o_valid   = ex_bundle.valid;
  assign o_uop     = ex_bundle.uop;
  assign o_rs1_ren = ex_bundle.rs1_ren;
  assign o_rs1     = ex_bundle.rs1;
  assign o_rs2_ren = ex_bundle.rs2_ren;
  assign o_rs2     = ex_bundle.rs2;
  assign o_rd_wen  = ex_bundle.rd_wen;
  assign o_rd      = ex_bundle.rd;
  assign o_op1     = ex_bundle.op1;
  assign o_op2     = ex_bundle.op2;
  assign o_op3     = ex_bundle.op3;

endmodule

//--- tb/tb_id_stage.sv
/* decode stage testbench */
`include "rv_defs.svh"

module tb_id_stage;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 20;
  localparam int MAX_ROWS   = 128;

  logic               clock;
  logic               rst;
  logic               i_valid;
  logic [`ILEN-1:0]   i_inst;
  logic [`XLEN-1:0]   i_pc;
  logic [`XLEN-1:0]   i_rs1_data;
  logic [`XLEN-1:0]   i_rs2_data;
  logic               o_valid;
  logic [`UOP_W-1:0]  o_uop;
  logic               o_rs1_ren;
  logic [`RIDX_W-1:0] o_rs1;
  logic               o_rs2_ren;
  logic [`RIDX_W-1:0] o_rs2;
  logic               o_rd_wen;
  logic [`RIDX_W-1:0] o_rd;
  logic [`XLEN-1:0]   o_op1;
  logic [`XLEN-1:0]   o_op2;
  logic [`XLEN-1:0]   o_op3;

  // row 0 is the reset check, file rows follow
  logic [8*24-1:0]    row_name [0:MAX_ROWS-1];
  logic [63:0]        row_data [0:MAX_ROWS-1][0:15];
  int                 n_rows;
  int                 pass_count;
  int                 fail_count;
  int                 load_errors;
  logic               loaded;
  logic               test_bad;

  id_stage_top dut_i (
    .clock      (clock),
    .rst        (rst),
    .i_valid    (i_valid),
    .i_inst     (i_inst),
    .i_pc       (i_pc),
    .i_rs1_data (i_rs1_data),
    .i_rs2_data (i_rs2_data),
    .o_valid    (o_valid),
    .o_uop      (o_uop),
    .o_rs1_ren  (o_rs1_ren),
    .o_rs1      (o_rs1),
    .o_rs2_ren  (o_rs2_ren),
    .o_rs2      (o_rs2),
    .o_rd_wen   (o_rd_wen),
    .o_rd       (o_rd),
    .o_op1      (o_op1),
    .o_op2      (o_op2),
    .o_op3      (o_op3)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  task automatic load_tests();
    int fd;
    int cnt;
    int k;
    int line_no;
    logic [8*256-1:0] line_buf;
    logic [8*24-1:0]  name_buf;
    row_name[0] = "reset";
    for (k = 0; k < 16; k++) begin
      row_data[0][k] = '0;
    end
    // a valid add is held on the inputs during reset
    row_data[0][0] = 64'h1;
    row_data[0][1] = 64'h00b50533;
    row_data[0][2] = 64'h1000;
    row_data[0][3] = 64'h5;
    row_data[0][4] = 64'h7;
    n_rows  = 1;
    line_no = 0;
    fd = $fopen("tb/decode_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test file tb/decode_tests.txt");
      load_errors++;
    end else begin
      while ($fgets(line_buf, fd) != 0 && n_rows < MAX_ROWS) begin
        line_no++;
        name_buf = '0;
        cnt = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      name_buf, row_data[n_rows][0], row_data[n_rows][1],
                      row_data[n_rows][2], row_data[n_rows][3], row_data[n_rows][4],
                      row_data[n_rows][5], row_data[n_rows][6], row_data[n_rows][7],
                      row_data[n_rows][8], row_data[n_rows][9], row_data[n_rows][10],
                      row_data[n_rows][11], row_data[n_rows][12], row_data[n_rows][13],
                      row_data[n_rows][14], row_data[n_rows][15]);
        if (cnt == 17) begin
          row_name[n_rows] = name_buf;
          n_rows++;
        end else if (cnt > 0 && name_buf != "#") begin
          $display("line %0d of the test file could not be read as a test", line_no);
          load_errors++;
        end
      end
      $fclose(fd);
    end
    if (n_rows < 2) begin
      $display("no tests were read from the test file");
      load_errors++;
    end
  endtask

  task automatic drive_inputs(input int idx);
    i_valid    = row_data[idx][0][0];
    i_inst     = row_data[idx][1][`ILEN-1:0];
    i_pc       = row_data[idx][2];
    i_rs1_data = row_data[idx][3];
    i_rs2_data = row_data[idx][4];
  endtask

  task automatic drive_bubble();
    i_valid    = 1'b0;
    i_inst     = '0;
    i_pc       = '0;
    i_rs1_data = '0;
    i_rs2_data = '0;
  endtask

  task automatic report_mismatch(input int idx, input string field,
                                 input logic [63:0] exp_val, input logic [63:0] act_val);
    // first wrong field of a test gives its line
    if (!test_bad) begin
      $display("FAILED %0s %0s: expected %h, actual %h", row_name[idx], field, exp_val,
               act_val);
    end
    test_bad = 1'b1;
  endtask

  task automatic check_outputs(input int idx);
    test_bad = 1'b0;
    if (64'(o_valid) !== row_data[idx][5])
      report_mismatch(idx, "valid", row_data[idx][5], 64'(o_valid));
    if (64'(o_uop) !== row_data[idx][6])
      report_mismatch(idx, "uop", row_data[idx][6], 64'(o_uop));
    if (64'(o_rs1_ren) !== row_data[idx][7])
      report_mismatch(idx, "rs1_ren", row_data[idx][7], 64'(o_rs1_ren));
    if (64'(o_rs1) !== row_data[idx][8])
      report_mismatch(idx, "rs1", row_data[idx][8], 64'(o_rs1));
    if (64'(o_rs2_ren) !== row_data[idx][9])
      report_mismatch(idx, "rs2_ren", row_data[idx][9], 64'(o_rs2_ren));
    if (64'(o_rs2) !== row_data[idx][10])
      report_mismatch(idx, "rs2", row_data[idx][10], 64'(o_rs2));
    if (64'(o_rd_wen) !== row_data[idx][11])
      report_mismatch(idx, "rd_wen", row_data[idx][11], 64'(o_rd_wen));
    if (64'(o_rd) !== row_data[idx][12])
      report_mismatch(idx, "rd", row_data[idx][12], 64'(o_rd));
    if (o_op1 !== row_data[idx][13])
      report_mismatch(idx, "op1", row_data[idx][13], o_op1);
    if (o_op2 !== row_data[idx][14])
      report_mismatch(idx, "op2", row_data[idx][14], o_op2);
    if (o_op3 !== row_data[idx][15])
      report_mismatch(idx, "op3", row_data[idx][15], o_op3);
    if (test_bad) begin
      fail_count++;
    end else begin
      pass_count++;
      $display("ok %0s", row_name[idx]);
    end
  endtask

  // run length follows the number of tests read
  initial begin
    wait (loaded === 1'b1);
    #((n_rows + 10) * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", n_rows + 10);
    $display("Test failures found");
    $finish;
  end

  initial begin
    int i;
    rst         = 1'b1;
    loaded      = 1'b0;
    pass_count  = 0;
    fail_count  = 0;
    load_errors = 0;
    drive_bubble();
    load_tests();
    drive_inputs(0);
    loaded = 1'b1;
    repeat (4) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
    check_outputs(0);
    if (n_rows > 1) begin
      drive_inputs(1);
    end else begin
      drive_bubble();
    end
    // each row is checked one cycle after it is driven
    for (i = 1; i < n_rows; i++) begin
      @(negedge clock);
      check_outputs(i);
      if (i + 1 < n_rows) begin
        drive_inputs(i + 1);
      end else begin
        drive_bubble();
      end
    end
    $display("tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && load_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+logic
logic/isa_pkg.sv
logic/decode_pkg.sv
logic/decode_if.sv
logic/inst_classifier.sv
logic/imm_gen.sv
logic/operand_mux.sv
logic/id_ex_reg.sv
logic/id_stage_top.sv
tb/tb_id_stage.sv

//--- tb/decode_tests.txt
# name valid inst pc rs1_data rs2_data, then expected: valid uop rs1_ren rs1
# rs2_ren rs2 rd_wen rd op1 op2 op3 (all values hex)
bubble_add 0 00b50533 1000 5 7 0 0 0 0 0 0 0 0 0 0 0
add 1 00b50533 1000 5 7 1 1f 1 a 1 b 1 a 5 7 0
sub 1 402081b3 1004 ffffffffffffffff 1 1 20 1 1 1 2 1 3 ffffffffffffffff 1 0
sra 1 407352b3 1008 8000000000000000 3f 1 26 1 6 1 7 1 5 8000000000000000 3f 0
and 1 01df7fb3 100c f0f0 ff00 1 28 1 1e 1 1d 1 1f f0f0 ff00 0
addi_neg 1 fff10093 1010 10 0 1 16 1 2 0 0 1 1 10 ffffffffffffffff 0
slti_max 1 7ff2a213 1014 20 99 1 17 1 5 0 0 1 4 20 7ff 0
xori_min 1 8003c313 1018 30 0 1 19 1 7 0 0 1 6 30 fffffffffffff800 0
slli_63 1 03f49413 101c 1 0 1 1c 1 9 0 0 1 8 1 3f 0
srai_33 1 4215d513 1020 ffff0000 0 1 1e 1 b 0 0 1 a ffff0000 21 0
srli_1 1 0016d613 1024 2 0 1 1d 1 d 0 0 1 c 2 1 0
addiw_neg 1 ffb7871b 1028 7 0 1 29 1 f 0 0 1 e 7 fffffffffffffffb 0
slliw_31 1 01f8981b 102c 3 0 1 2a 1 11 0 0 1 10 3 1f 0
sraiw_7 1 4079d91b 1030 80000000 0 1 2c 1 13 0 0 1 12 80000000 7 0
srliw_5bit 1 027ada1b 1034 ff 0 1 2b 1 15 0 0 1 14 ff 7 0
addw 1 003100bb 1038 1 2 1 2d 1 2 1 3 1 1 1 2 0
subw 1 4062823b 103c 5 6 1 2e 1 5 1 6 1 4 5 6 0
sraw 1 409453bb 1040 a b 1 31 1 8 1 9 1 7 a b 0
ld_neg 1 ff813503 1044 2000 0 1 e 1 2 0 0 1 a 2000 fffffffffffffff8 fffffffffffffff8
lbu 1 01064583 1048 3000 0 1 f 1 c 0 0 1 b 3000 10 10
lwu_max 1 7ff76683 104c 4000 0 1 11 1 e 0 0 1 d 4000 7ff 7ff
sd_neg 1 fe533823 1050 5000 1234 1 15 1 6 1 5 0 0 5000 1234 fffffffffffffff0
sb 1 007402a3 1054 6000 ab 1 12 1 8 1 7 0 0 6000 ab 5
sw 1 7e952223 1058 7000 cd 1 14 1 a 1 9 0 0 7000 cd 7e4
beq_fwd 1 00208863 1000 1 2 1 5 1 1 1 2 0 0 1 2 1010
bne_back 1 fe419ee3 2000 3 4 1 6 1 3 1 4 0 0 3 4 1ffc
bltu_wrap 1 fe62ece3 4 5 6 1 9 1 5 1 6 0 0 5 6 fffffffffffffffc
bge_2k 1 0083d0e3 1000 7 8 1 8 1 7 1 8 0 0 7 8 1800
branch_bad_f3 1 0020a863 1000 1 2 1 0 0 0 0 0 0 0 0 0 0
jal_fwd 1 001000ef 1000 0 0 1 3 0 0 0 0 1 1 1000 4 1800
jal_back 1 ffdff06f 10 0 0 1 3 0 0 0 0 1 0 10 4 c
jalr 1 00c280e7 3000 100 0 1 4 1 5 0 0 1 1 100 c 3004
jalr_wrap 1 fff18167 fffffffffffffffc 8 0 1 4 1 3 0 0 1 2 8 ffffffffffffffff 0
lui 1 800002b7 1000 0 0 1 1 0 0 0 0 1 5 ffffffff80000000 1000 0
auipc 1 12345317 2000 0 0 1 2 0 0 0 0 1 6 12345000 2000 0
ecall 1 00000073 1000 1 2 1 0 0 0 0 0 0 0 0 0 0
csrrw 1 300110f3 1004 3 4 1 0 0 0 0 0 0 0 0 0 0
fence 1 0ff0000f 1008 5 6 1 0 0 0 0 0 0 0 0 0 0
# burst of mixed instructions and bubbles
burst_jal 1 001000ef 2000 0 0 1 3 0 0 0 0 1 1 2000 4 2800
burst_bubble 0 fe533823 2004 1 2 0 0 0 0 0 0 0 0 0 0 0
burst_sd 1 fe533823 2008 aa bb 1 15 1 6 1 5 0 0 aa bb fffffffffffffff0
burst_lui 1 800002b7 200c 0 0 1 1 0 0 0 0 1 5 ffffffff80000000 200c 0
burst_sub 1 402081b3 2010 9 4 1 20 1 1 1 2 1 3 9 4 0
burst_ecall 1 00000073 2014 9 4 1 0 0 0 0 0 0 0 0 0 0
burst_addi 1 fff10093 2018 11 0 1 16 1 2 0 0 1 1 11 ffffffffffffffff 0
burst_end 0 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0
